// ==== vlog.f ====
+incdir+src
src/hmc_init_pkg.sv
src/hmc_init_seq.sv
src/hmc_rf.sv
src/hmc_link_train.sv
src/hmc_init_top.sv
testbench/tb_clk_gen.sv
testbench/tb_hmc_init.sv

// ==== Bender.yml ====
package:
  name: hmc_init

export_include_dirs:
  - src

sources:
  - src/hmc_init_pkg.sv
  - src/hmc_init_seq.sv
  - src/hmc_rf.sv
  - src/hmc_link_train.sv
  - src/hmc_init_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_hmc_init.sv

// ==== testbench/tb_hmc_init.sv ====
`timescale 1ns/1ps
`include "hmc_rf_defs.svh"

module tb_hmc_init;

  localparam int SEED        = 84;
  localparam int DELAY_MIN   = 20;
  localparam int DELAY_MAX   = 200;
  localparam int SLACK       = 12;
  localparam int HOLD_CYCLES = 100;
  localparam int ABORT_LANES = 2;
  // three runs of worst iic delay, done bound and margin
  localparam int WD_CYCLES = 3 * (DELAY_MAX + `HMC_NUM_LANES * `HMC_LOCK_INTERVAL +
                                  `HMC_ALIGN_DELAY + `HMC_LINKUP_DELAY + SLACK + 50);

  logic clk_hmc;
  logic rst_i;
  logic rst_req;
  logic iic_init_done;
  logic init_done;
  logic p_rst_n;
  logic init_cont;
  logic link_up;
  hmc_init_pkg::lane_mask_t lane_lock;

  int pass_cnt = 0;
  int fail_cnt = 0;
  int seed_val;
  int prev_count = 0;
  // monitor verdicts since the previous run's checks
  bit mono_ok      = 1'b1;
  bit order_ok     = 1'b1;
  bit lock_link_ok = 1'b1;
  bit done_link_ok = 1'b1;

  tb_clk_gen i_tb_clk_gen (
    .rst_req_i (rst_req),
    .clk_hmc   (clk_hmc),
    .rst_o     (rst_i)
  );

  hmc_init_top i_hmc_init_top (
    .clk_hmc         (clk_hmc),
    .rst_i           (rst_i),
    .iic_init_done_i (iic_init_done),
    .init_done_o     (init_done),
    .p_rst_n_o       (p_rst_n),
    .init_cont_o     (init_cont),
    .lane_lock_o     (lane_lock),
    .link_up_o       (link_up)
  );

  // --------------------
  // reference and compare
  // --------------------
  // all lanes, then alignment, then link-up, plus polling slack
  function automatic void expected_done_window(output int earliest, output int latest);
    earliest = `HMC_NUM_LANES * `HMC_LOCK_INTERVAL + `HMC_ALIGN_DELAY + `HMC_LINKUP_DELAY;
    latest   = earliest + SLACK;
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act === exp) begin
      pass_cnt++;
      $display("ok      %s = %b", name, act);
    end else begin
      fail_cnt++;
      $display("** Error: %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_lanes(input string name, input hmc_init_pkg::lane_mask_t exp,
                             input hmc_init_pkg::lane_mask_t act);
    if (act === exp) begin
      pass_cnt++;
      $display("ok      %s = %b", name, act);
    end else begin
      fail_cnt++;
      $display("** Error: %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_cycle(input string name, input int lo, input int hi, input int act);
    if (act >= lo && act <= hi) begin
      pass_cnt++;
      $display("ok      %s = %0d cycles", name, act);
    end else begin
      fail_cnt++;
      $display("** Error: %s: expected %0d..%0d, actual %0d", name, lo, hi, act);
    end
  endtask

  // --------------------
  // monitor
  // --------------------
  // pre-edge values, so lane order and link rules hold every cycle
  always @(posedge clk_hmc) begin
    if (rst_i) begin
      prev_count = 0;
    end else begin
      if ($countones(lane_lock) < prev_count && mono_ok) begin
        $display("lane_lock_o lost a locked lane at %0t", $time);
        mono_ok = 1'b0;
      end
      // locked lanes must form a run from lane 0 upward
      if (((lane_lock & (lane_lock + 1)) != 0) && order_ok) begin
        $display("lane_lock_o locked lanes out of order at %0t", $time);
        order_ok = 1'b0;
      end
      if (link_up && lane_lock != '1 && lock_link_ok) begin
        $display("link_up_o was high with lanes still unlocked at %0t", $time);
        lock_link_ok = 1'b0;
      end
      if (init_done && !link_up && done_link_ok) begin
        $display("init_done_o was high while link_up_o was low at %0t", $time);
        done_link_ok = 1'b0;
      end
      prev_count = $countones(lane_lock);
    end
  end

  // verdicts start over once a run has checked them
  task automatic reset_monitor_flags();
    mono_ok      = 1'b1;
    order_ok     = 1'b1;
    lock_link_ok = 1'b1;
    done_link_ok = 1'b1;
  endtask

  // --------------------
  // stimulus
  // --------------------
  task automatic start_reset();
    @(posedge clk_hmc);
    rst_req       <= 1'b1;
    iic_init_done <= 1'b0;
    @(posedge clk_hmc);
    rst_req       <= 1'b0;
  endtask

  task automatic wait_reset_release();
    do begin
      @(negedge clk_hmc);
    end while (rst_i);
  endtask

  task automatic run_bringup(input string tag, input bit abort);
    int delay;
    int lat;
    int link_at;
    int earliest;
    int latest;
    bit saw_rel;
    bit saw_cont;
    bit early_done;
    bit held;
    hmc_init_pkg::lane_mask_t lanes_seen;
    expected_done_window(earliest, latest);
    wait_reset_release();
    check_bit({tag, " init_done out of reset"}, 1'b0, init_done);
    check_bit({tag, " p_rst_n out of reset"}, 1'b0, p_rst_n);
    check_bit({tag, " init_cont out of reset"}, 1'b0, init_cont);
    delay = DELAY_MIN + ($urandom % (DELAY_MAX - DELAY_MIN + 1));
    $display("%s: iic delay %0d cycles", tag, delay);
    saw_rel    = 1'b0;
    saw_cont   = 1'b0;
    early_done = 1'b0;
    lanes_seen = '0;
    // device released, but nothing trains before i2c is done
    repeat (delay) begin
      @(negedge clk_hmc);
      saw_rel    = saw_rel | p_rst_n;
      saw_cont   = saw_cont | init_cont;
      early_done = early_done | init_done;
      lanes_seen = lanes_seen | lane_lock;
    end
    check_bit({tag, " p_rst_n before iic"}, 1'b1, saw_rel);
    check_bit({tag, " init_cont before iic"}, 1'b0, saw_cont);
    check_lanes({tag, " lanes before iic"}, '0, lanes_seen);
    check_bit({tag, " init_done before iic"}, 1'b0, early_done);
    @(posedge clk_hmc);
    iic_init_done <= 1'b1;
    lat     = 0;
    link_at = -1;
    if (abort) begin
      // stop partway, after the first lanes lock
      do begin
        @(negedge clk_hmc);
        lat++;
      end while ($countones(lane_lock) < ABORT_LANES && lat < latest);
      check_lanes({tag, " lanes partway"}, (1 << ABORT_LANES) - 1, lane_lock);
      start_reset();
      do begin
        @(negedge clk_hmc);
      end while (!rst_i);
      @(negedge clk_hmc);
      check_bit({tag, " init_done in reset"}, 1'b0, init_done);
      check_bit({tag, " p_rst_n in reset"}, 1'b0, p_rst_n);
      check_bit({tag, " init_cont in reset"}, 1'b0, init_cont);
      check_bit({tag, " link_up in reset"}, 1'b0, link_up);
      check_lanes({tag, " lanes in reset"}, '0, lane_lock);
      check_bit({tag, " lanes never drop"}, 1'b1, mono_ok);
      check_bit({tag, " lanes lock in order"}, 1'b1, order_ok);
      check_bit({tag, " lanes locked before link-up"}, 1'b1, lock_link_ok);
      check_bit({tag, " init_done only with link-up"}, 1'b1, done_link_ok);
      reset_monitor_flags();
      return;
    end
    saw_cont = 1'b0;
    do begin
      @(posedge clk_hmc);
      lat++;
      @(negedge clk_hmc);
      saw_cont = saw_cont | init_cont;
      if (link_up && link_at < 0) begin
        link_at = lat;
        check_lanes({tag, " lanes at link-up"}, '1, lane_lock);
      end
    end while (!init_done && lat < latest + 20);
    check_bit({tag, " init_cont after iic"}, 1'b1, saw_cont);
    check_cycle({tag, " init_done latency"}, earliest, latest, lat);
    check_bit({tag, " init_done after link-up"}, 1'b1, link_at >= 0 && link_at < lat);
    held = 1'b1;
    repeat (HOLD_CYCLES) begin
      @(negedge clk_hmc);
      if (!init_done) begin
        held = 1'b0;
      end
    end
    check_bit({tag, " init_done held"}, 1'b1, held);
    check_bit({tag, " lanes never drop"}, 1'b1, mono_ok);
    check_bit({tag, " lanes lock in order"}, 1'b1, order_ok);
    check_bit({tag, " lanes locked before link-up"}, 1'b1, lock_link_ok);
    check_bit({tag, " init_done only with link-up"}, 1'b1, done_link_ok);
    reset_monitor_flags();
  endtask

  initial begin
    rst_req       = 1'b0;
    iic_init_done = 1'b0;
    seed_val      = $urandom(SEED);
    run_bringup("run1", 1'b0);
    start_reset();
    // second run is cut short by a reset
    run_bringup("run2", 1'b1);
    run_bringup("run3", 1'b0);
    $display("summary: %0d checks passed, %0d checks failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WD_CYCLES) @(posedge clk_hmc);
    $display("timeout: bring-up runs did not finish within %0d cycles", WD_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  input  logic rst_req_i,
  output logic clk_hmc,
  output logic rst_o
);

  localparam int RST_CYCLES = 8;

  int rst_cnt;

  initial begin
    clk_hmc = 1'b0;
    rst_o   = 1'b1;
    rst_cnt = 0;
  end

  // 20 ns period
  always #10 clk_hmc = ~clk_hmc;

  // reset held for 8 rising edges, restarted on request
  always @(posedge clk_hmc) begin
    if (rst_req_i) begin
      rst_o   <= 1'b1;
      rst_cnt <= 0;
    end else if (rst_o) begin
      if (rst_cnt == RST_CYCLES - 1) begin
        rst_o <= 1'b0;
      end else begin
        rst_cnt <= rst_cnt + 1;
      end
    end
  end

endmodule

// ==== src/hmc_init_top.sv ====
`timescale 1ns/1ps

module hmc_init_top (
  input  logic                       clk_hmc,
  input  logic                       rst_i,
  input  logic                       iic_init_done_i,
  output logic                       init_done_o,
  output logic                       p_rst_n_o,
  output logic                       init_cont_o,
  output hmc_init_pkg::lane_mask_t   lane_lock_o,
  output logic                       link_up_o
);

  // --------------------
  // register file port
  // --------------------
  hmc_init_pkg::rf_addr_e rf_address;
  hmc_init_pkg::rf_data_t rf_write_data;
  hmc_init_pkg::rf_data_t rf_read_data;
  logic                   rf_read_en;
  logic                   rf_write_en;
  logic                   rf_access_complete;
  logic                   rf_invalid_address;
  // alignment only reaches the status word
  logic                   lanes_aligned;

  hmc_init_seq i_hmc_init_seq (
    .clk_hmc              (clk_hmc),
    .rst_i                (rst_i),
    .iic_init_done_i      (iic_init_done_i),
    .rf_address_o         (rf_address),
    .rf_read_en_o         (rf_read_en),
    .rf_write_en_o        (rf_write_en),
    .rf_write_data_o      (rf_write_data),
    .rf_read_data_i       (rf_read_data),
    .rf_access_complete_i (rf_access_complete),
    .rf_invalid_address_i (rf_invalid_address),
    .init_done_o          (init_done_o)
  );

  hmc_rf i_hmc_rf (
    .clk_hmc              (clk_hmc),
    .rst_i                (rst_i),
    .rf_address_i         (rf_address),
    .rf_read_en_i         (rf_read_en),
    .rf_write_en_i        (rf_write_en),
    .rf_write_data_i      (rf_write_data),
    .rf_read_data_o       (rf_read_data),
    .rf_access_complete_o (rf_access_complete),
    .rf_invalid_address_o (rf_invalid_address),
    .lane_lock_i          (lane_lock_o),
    .lanes_aligned_i      (lanes_aligned),
    .link_up_i            (link_up_o),
    .ctrl_p_rst_n_o       (p_rst_n_o),
    .ctrl_init_cont_o     (init_cont_o)
  );

  // stands in for the serdes and the device side of training
  hmc_link_train i_hmc_link_train (
    .clk_hmc         (clk_hmc),
    .rst_i           (rst_i),
    .p_rst_n_i       (p_rst_n_o),
    .init_cont_i     (init_cont_o),
    .lane_lock_o     (lane_lock_o),
    .lanes_aligned_o (lanes_aligned),
    .link_up_o       (link_up_o)
  );

endmodule

// ==== src/hmc_link_train.sv ====
`timescale 1ns/1ps
`include "hmc_rf_defs.svh"

module hmc_link_train (
  input  logic                       clk_hmc,
  input  logic                       rst_i,
  input  logic                       p_rst_n_i,
  input  logic                       init_cont_i,
  output hmc_init_pkg::lane_mask_t   lane_lock_o,
  output logic                       lanes_aligned_o,
  output logic                       link_up_o
);

  // --------------------
  // training milestones
  // --------------------
  // last lane locks here
  localparam int LOCK_DONE = `HMC_NUM_LANES * `HMC_LOCK_INTERVAL;
  localparam int ALIGN_AT  = LOCK_DONE + `HMC_ALIGN_DELAY;
  localparam int LINKUP_AT = ALIGN_AT + `HMC_LINKUP_DELAY;
  localparam int CNT_W     = $clog2(LINKUP_AT + 1);

  // cycles since init_cont_set, saturates at link-up
  logic [CNT_W-1:0] train_cnt_q;
  logic             cnt_sat;

  assign cnt_sat = (train_cnt_q == CNT_W'(LINKUP_AT));

  // device in reset holds training at zero
  always_ff @(posedge clk_hmc) begin
    if (rst_i || !p_rst_n_i) begin
      train_cnt_q <= '0;
    end else if (init_cont_i && !cnt_sat) begin
      train_cnt_q <= train_cnt_q + 1'b1;
    end
  end

  // lane n locks after (n+1) lock intervals
  always_comb begin
    for (int n = 0; n < `HMC_NUM_LANES; n++) begin
      lane_lock_o[n] = (train_cnt_q >= CNT_W'((n + 1) * `HMC_LOCK_INTERVAL));
    end
  end

  // alignment then link-up follow the last lock
  assign lanes_aligned_o = (train_cnt_q >= CNT_W'(ALIGN_AT));
  assign link_up_o       = cnt_sat;

endmodule

// ==== src/hmc_rf.sv ====
`timescale 1ns/1ps
`include "hmc_rf_defs.svh"

module hmc_rf (
  input  logic                       clk_hmc,
  input  logic                       rst_i,
  // access port
  input  hmc_init_pkg::rf_addr_e     rf_address_i,
  input  logic                       rf_read_en_i,
  input  logic                       rf_write_en_i,
  input  hmc_init_pkg::rf_data_t     rf_write_data_i,
  output hmc_init_pkg::rf_data_t     rf_read_data_o,
  output logic                       rf_access_complete_o,
  output logic                       rf_invalid_address_o,
  // live link state from training
  input  hmc_init_pkg::lane_mask_t   lane_lock_i,
  input  logic                       lanes_aligned_i,
  input  logic                       link_up_i,
  // control outputs to the link
  output logic                       ctrl_p_rst_n_o,
  output logic                       ctrl_init_cont_o
);

  // writable bits of control: p_rst_n, init_cont_set and tokens
  localparam hmc_init_pkg::rf_data_t CTRL_WR_MASK =
    (hmc_init_pkg::rf_data_t'(1) << `CTRL_P_RST_N_BIT) |
    (hmc_init_pkg::rf_data_t'(1) << `CTRL_INIT_CONT_BIT) |
    (hmc_init_pkg::rf_data_t'({`CTRL_TOKENS_WIDTH{1'b1}}) << `CTRL_TOKENS_LSB);

  hmc_init_pkg::rf_data_t control_q;
  hmc_init_pkg::rf_data_t status_init;
  hmc_init_pkg::rf_data_t status_general;
  hmc_init_pkg::rf_data_t rd_mux;
  logic addr_valid;
  logic wr_ctrl;
  logic access;

  // --------------------
  // status words
  // --------------------
  always_comb begin
    status_init = '0;
    status_init[`HMC_NUM_LANES-1:0] = lane_lock_i;
    status_init[`STAT_INIT_ALIGNED_BIT] = lanes_aligned_i;
  end

  always_comb begin
    status_general = '0;
    status_general[`STAT_GEN_LINK_UP_BIT] = link_up_i;
  end

  // address decode, unknown addresses read zero
  always_comb begin
    rd_mux     = '0;
    addr_valid = 1'b1;
    case (rf_address_i)
      hmc_init_pkg::STATUS_GENERAL: rd_mux = status_general;
      hmc_init_pkg::STATUS_INIT:    rd_mux = status_init;
      hmc_init_pkg::CONTROL:        rd_mux = control_q;
      default:                      addr_valid = 1'b0;
    endcase
  end

  assign access  = rf_read_en_i | rf_write_en_i;
  // status registers are read only, writes there are dropped
  assign wr_ctrl = rf_write_en_i && (rf_address_i == hmc_init_pkg::CONTROL);

  // --------------------
  // control register
  // --------------------
  always_ff @(posedge clk_hmc) begin
    if (rst_i) begin
      control_q <= '0;
    end else if (wr_ctrl) begin
      control_q <= (control_q & ~CTRL_WR_MASK) | (rf_write_data_i & CTRL_WR_MASK);
    end
  end

  // completion one cycle after the enable
  always_ff @(posedge clk_hmc) begin
    if (rst_i) begin
      rf_access_complete_o <= 1'b0;
      rf_invalid_address_o <= 1'b0;
    end else begin
      rf_access_complete_o <= access;
      rf_invalid_address_o <= access && !addr_valid;
    end
  end

  // read data captured with the enable
  always_ff @(posedge clk_hmc) begin
    if (rf_read_en_i) begin
      rf_read_data_o <= rd_mux;
    end
  end

  assign ctrl_p_rst_n_o   = control_q[`CTRL_P_RST_N_BIT];
  assign ctrl_init_cont_o = control_q[`CTRL_INIT_CONT_BIT];

endmodule

// ==== src/hmc_init_seq.sv ====
`timescale 1ns/1ps
`include "hmc_rf_defs.svh"

module hmc_init_seq (
  input  logic                     clk_hmc,
  input  logic                     rst_i,
  input  logic                     iic_init_done_i,
  // register file port
  output hmc_init_pkg::rf_addr_e   rf_address_o,
  output logic                     rf_read_en_o,
  output logic                     rf_write_en_o,
  output hmc_init_pkg::rf_data_t   rf_write_data_o,
  input  hmc_init_pkg::rf_data_t   rf_read_data_i,
  input  logic                     rf_access_complete_i,
  input  logic                     rf_invalid_address_i,
  output logic                     init_done_o
);

  // --------------------
  // control words
  // --------------------
  // release word: p_rst_n plus the token count
  localparam hmc_init_pkg::rf_data_t RELEASE_WORD =
    (hmc_init_pkg::rf_data_t'(`CTRL_TOKENS_VAL) << `CTRL_TOKENS_LSB) |
    (hmc_init_pkg::rf_data_t'(1) << `CTRL_P_RST_N_BIT);
  // same word with init_cont_set, lets the descramblers lock
  localparam hmc_init_pkg::rf_data_t INIT_CONT_WORD =
    RELEASE_WORD | (hmc_init_pkg::rf_data_t'(1) << `CTRL_INIT_CONT_BIT);

  hmc_init_pkg::init_state_e state_q;
  logic lanes_ready;
  logic link_ready;

  // every lane locked and the lanes aligned
  assign lanes_ready = (&rf_read_data_i[`HMC_NUM_LANES-1:0]) &&
                       rf_read_data_i[`STAT_INIT_ALIGNED_BIT];
  assign link_ready  = rf_read_data_i[`STAT_GEN_LINK_UP_BIT];

  // --------------------
  // state machine
  // --------------------
  always_ff @(posedge clk_hmc) begin
    if (rst_i) begin
      state_q       <= hmc_init_pkg::IDLE;
      rf_read_en_o  <= 1'b0;
      rf_write_en_o <= 1'b0;
      init_done_o   <= 1'b0;
    end else begin
      // enables are single-cycle pulses
      rf_read_en_o  <= 1'b0;
      rf_write_en_o <= 1'b0;
      case (state_q)
        hmc_init_pkg::IDLE: begin
          state_q <= hmc_init_pkg::WR_RELEASE_RST;
        end
        // take the device out of reset
        hmc_init_pkg::WR_RELEASE_RST: begin
          rf_write_en_o <= 1'b1;
          state_q       <= hmc_init_pkg::WAIT_WR_RELEASE;
        end
        hmc_init_pkg::WAIT_WR_RELEASE: begin
          if (rf_access_complete_i) begin
            state_q <= hmc_init_pkg::WAIT_IIC_DONE;
          end
        end
        // external i2c config must finish first
        hmc_init_pkg::WAIT_IIC_DONE: begin
          if (iic_init_done_i) begin
            state_q <= hmc_init_pkg::WR_INIT_CONT;
          end
        end
        hmc_init_pkg::WR_INIT_CONT: begin
          rf_write_en_o <= 1'b1;
          state_q       <= hmc_init_pkg::WAIT_WR_INIT;
        end
        hmc_init_pkg::WAIT_WR_INIT: begin
          if (rf_access_complete_i) begin
            state_q <= hmc_init_pkg::RD_STATUS_INIT;
          end
        end
        // poll status_init for lock and alignment
        hmc_init_pkg::RD_STATUS_INIT: begin
          rf_read_en_o <= 1'b1;
          state_q      <= hmc_init_pkg::WAIT_RD_INIT;
        end
        hmc_init_pkg::WAIT_RD_INIT: begin
          if (rf_access_complete_i) begin
            // invalid address or not ready yet, same read again
            if (!rf_invalid_address_i && lanes_ready) begin
              state_q <= hmc_init_pkg::RD_STATUS_GEN;
            end else begin
              state_q <= hmc_init_pkg::RD_STATUS_INIT;
            end
          end
        end
        // poll status_general for link-up
        hmc_init_pkg::RD_STATUS_GEN: begin
          rf_read_en_o <= 1'b1;
          state_q      <= hmc_init_pkg::WAIT_RD_GEN;
        end
        hmc_init_pkg::WAIT_RD_GEN: begin
          if (rf_access_complete_i) begin
            if (!rf_invalid_address_i && link_ready) begin
              state_q <= hmc_init_pkg::INIT_COMPLETE;
            end else begin
              state_q <= hmc_init_pkg::RD_STATUS_GEN;
            end
          end
        end
        // link ready for flits, hold here until reset
        hmc_init_pkg::INIT_COMPLETE: begin
          init_done_o <= 1'b1;
        end
        default: begin
          state_q <= hmc_init_pkg::IDLE;
        end
      endcase
    end
  end

  // --------------------
  // access payload
  // --------------------
  always_ff @(posedge clk_hmc) begin
    case (state_q)
      hmc_init_pkg::WR_RELEASE_RST: begin
        rf_address_o    <= hmc_init_pkg::CONTROL;
        rf_write_data_o <= RELEASE_WORD;
      end
      hmc_init_pkg::WR_INIT_CONT: begin
        rf_address_o    <= hmc_init_pkg::CONTROL;
        rf_write_data_o <= INIT_CONT_WORD;
      end
      hmc_init_pkg::RD_STATUS_INIT: begin
        rf_address_o <= hmc_init_pkg::STATUS_INIT;
      end
      hmc_init_pkg::RD_STATUS_GEN: begin
        rf_address_o <= hmc_init_pkg::STATUS_GENERAL;
      end
      default: begin
        // hold the last access
      end
    endcase
  end

endmodule

// ==== src/hmc_init_pkg.sv ====
`include "hmc_rf_defs.svh"

package hmc_init_pkg;

  // sequencer states, one per step of link bring-up
  typedef enum logic [7:0] {
    IDLE            = 8'h00,
    WR_RELEASE_RST  = 8'h01,
    WAIT_WR_RELEASE = 8'h02,
    WAIT_IIC_DONE   = 8'h03,
    WR_INIT_CONT    = 8'h04,
    WAIT_WR_INIT    = 8'h05,
    RD_STATUS_INIT  = 8'h06,
    WAIT_RD_INIT    = 8'h07,
    RD_STATUS_GEN   = 8'h08,
    WAIT_RD_GEN     = 8'h09,
    INIT_COMPLETE   = 8'h0a
  } init_state_e;

  // implemented register addresses, counters above 0x2 are not modelled
  typedef enum logic [`HMC_RF_AWIDTH-1:0] {
    STATUS_GENERAL = 5'h0,
    STATUS_INIT    = 5'h1,
    CONTROL        = 5'h2
  } rf_addr_e;

  typedef logic [`HMC_RF_DWIDTH-1:0] rf_data_t;
  typedef logic [`HMC_NUM_LANES-1:0] lane_mask_t;

endpackage

// ==== src/hmc_rf_defs.svh ====
`ifndef HMC_RF_DEFS_SVH
`define HMC_RF_DEFS_SVH

// --------------------
// register file geometry
// --------------------
`define HMC_RF_AWIDTH 5
`define HMC_RF_DWIDTH 64

// link shape and training delays, in clk_hmc cycles
`define HMC_NUM_LANES 8
`define HMC_LOCK_INTERVAL 16
`define HMC_ALIGN_DELAY 8
`define HMC_LINKUP_DELAY 4

// --------------------
// control register fields
// --------------------
`define CTRL_P_RST_N_BIT 0
`define CTRL_INIT_CONT_BIT 1
`define CTRL_TOKENS_LSB 16
`define CTRL_TOKENS_WIDTH 10
`define CTRL_TOKENS_VAL 255

// status register fields
`define STAT_INIT_ALIGNED_BIT 48
`define STAT_GEN_LINK_UP_BIT 0

`endif
